// File: design/mem_cfg_pkg.sv
/* data RAM geometry for the 64-bit core
   the window is a power of two in size and starts on a multiple of its size
   ram_bytes must equal ram_words times 8 */
package mem_cfg_pkg;

    // data and address width
    localparam int xlen = 64;

    // byte address window of the RAM
    localparam logic [xlen-1:0] ram_base  = 64'h0000_0000_8000_0000;
    localparam logic [xlen-1:0] ram_bytes = 64'h0000_0000_0001_0000;

    // byte offset inside one doubleword
    localparam int dw_offset_bits = 3;

    // doubleword index into the array
    localparam int dw_index_bits = 13;
    localparam int ram_words     = 2 ** dw_index_bits;

endpackage

// File: design/lsu_pkg.sv
/* access encodings and lane helpers for the load/store pipeline
   accesses never cross a doubleword, so every mask fits in one word */
package lsu_pkg;
    import mem_cfg_pkg::*;

    // one byte enable per lane of a doubleword
    localparam int lanes = xlen / 8;

    typedef enum logic [1:0] {
        width_byte  = 2'b00,
        width_half  = 2'b01,
        width_word  = 2'b10,
        width_dword = 2'b11
    } access_width_t;

    typedef logic [lanes-1:0]          lane_mask_t;
    typedef logic [dw_index_bits-1:0]  dw_index_t;
    typedef logic [dw_offset_bits-1:0] offset_t;

    // bytes touched by one access
    function automatic logic [dw_offset_bits:0] width_bytes(access_width_t width);
        case (width)
            width_byte:  return 4'd1;
            width_half:  return 4'd2;
            width_word:  return 4'd4;
            default:     return 4'd8;
        endcase
    endfunction

    // lane mask of an access at offset zero
    function automatic lane_mask_t width_mask(access_width_t width);
        logic [lanes:0] ones;
        ones = {{lanes{1'b0}}, 1'b1} << width_bytes(width);
        ones = ones - 1'b1;
        return ones[lanes-1:0];
    endfunction

    // offset not a multiple of the access size
    function automatic logic misaligned(access_width_t width, offset_t offset);
        offset_t low_bits;
        low_bits = offset_t'(width_bytes(width) - 1'b1);
        return (offset & low_bits) != '0;
    endfunction

endpackage

// File: design/lsu_stage_if.sv
/* one access between two adjacent pipeline stages
   every field is meaningful only while valid is high, there is no ready */
`timescale 1ns/10ps

interface lsu_stage_if
    import mem_cfg_pkg::*, lsu_pkg::*;
();
    logic            valid;
    logic            we;
    logic            err;
    dw_index_t       dw_index;
    offset_t         offset;
    access_width_t   width;
    logic            is_unsigned;
    // lanes a store writes
    lane_mask_t      byte_en;
    // store data already on its byte lanes
    logic [xlen-1:0] wdata;
    // whole doubleword read by a load
    logic [xlen-1:0] rdata;

    modport src (
        output valid, we, err, dw_index, offset, width,
        output is_unsigned, byte_en, wdata, rdata
    );

    modport dst (
        input valid, we, err, dw_index, offset, width,
        input is_unsigned, byte_en, wdata, rdata
    );

endinterface

// File: design/lsu_align.sv
/* stage 1: window and alignment check, lane placement of the store
   an access with an error still flows down the pipe but carries no byte enables */
`timescale 1ns/10ps

module lsu_align
    import mem_cfg_pkg::*, lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_valid,
    input  logic            req_we,
    input  logic            req_unsigned,
    input  logic [xlen-1:0] req_addr,
    input  logic [xlen-1:0] req_wdata,
    input  access_width_t   req_width,
    lsu_stage_if.src        s1
);

    logic [xlen-1:0] rel_addr;
    logic            in_window;
    logic            addr_err;
    offset_t         offset;
    dw_index_t       dw_index;
    lane_mask_t      byte_en;
    logic [xlen-1:0] wdata_lane;

    always_comb begin
        rel_addr = req_addr - ram_base;
        // unsigned compare, so addresses below the base wrap and fail too
        in_window = rel_addr < ram_bytes;
        offset    = rel_addr[dw_offset_bits-1:0];
        dw_index  = rel_addr[dw_offset_bits +: dw_index_bits];
        addr_err  = !in_window || misaligned(req_width, offset);

        // base mask moved up to the addressed lane
        if (addr_err) begin
            byte_en = '0;
        end else begin
            byte_en = lane_mask_t'(width_mask(req_width) << offset);
        end

        wdata_lane = req_wdata << {offset, 3'b000};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1.valid <= 1'b0;
            s1.err   <= 1'b0;
        end else begin
            s1.valid <= req_valid;
            s1.err   <= req_valid && addr_err;
        end
    end

    // payload of the access
    always_ff @(posedge clk) begin
        s1.we          <= req_we;
        s1.dw_index    <= dw_index;
        s1.offset      <= offset;
        s1.width       <= req_width;
        s1.is_unsigned <= req_unsigned;
        s1.byte_en     <= byte_en;
        s1.wdata       <= wdata_lane;
    end

    // nothing read yet at this stage
    assign s1.rdata = '0;

    // a rejected access must never reach the array write port
    err_no_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        s1.valid && s1.err |-> s1.byte_en == '0);

endmodule

// File: design/lsu_ram.sv
/* stage 2: byte-enabled array of 8192 doublewords, registered read
   contents are undefined until written, no reset and no preload */
`timescale 1ns/10ps

module lsu_ram
    import mem_cfg_pkg::*, lsu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    lsu_stage_if.dst s1,
    lsu_stage_if.src s2
);

    logic [xlen-1:0] mem [ram_words];
    logic            wr_en;
    logic            rd_en;
    logic [xlen-1:0] rd_word;

    // store from the previous cycle
    logic            last_wr_q;
    dw_index_t       last_idx_q;
    lane_mask_t      last_be_q;
    logic [xlen-1:0] last_data_q;

    assign wr_en = s1.valid && s1.we && !s1.err;
    assign rd_en = s1.valid && !s1.we && !s1.err;

    always_ff @(posedge clk) begin
        for (int i = 0; i < lanes; i++) begin
            if (wr_en && s1.byte_en[i]) begin
                mem[s1.dw_index][8*i +: 8] <= s1.wdata[8*i +: 8];
            end
        end
    end

    // bytes of the store one cycle back win over the array word
    always_comb begin
        rd_word = mem[s1.dw_index];
        for (int i = 0; i < lanes; i++) begin
            if (last_wr_q && last_idx_q == s1.dw_index && last_be_q[i]) begin
                rd_word[8*i +: 8] = last_data_q[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_wr_q <= 1'b0;
            s2.valid  <= 1'b0;
            s2.err    <= 1'b0;
        end else begin
            last_wr_q <= wr_en;
            s2.valid  <= s1.valid;
            s2.err    <= s1.valid && s1.err;
        end
    end

    always_ff @(posedge clk) begin
        last_idx_q     <= s1.dw_index;
        last_be_q      <= s1.byte_en;
        last_data_q    <= s1.wdata;
        s2.we          <= s1.we;
        s2.dw_index    <= s1.dw_index;
        s2.offset      <= s1.offset;
        s2.width       <= s1.width;
        s2.is_unsigned <= s1.is_unsigned;
        if (rd_en) begin
            s2.rdata <= rd_word;
        end
    end

    // store payload ends here
    assign s2.byte_en = '0;
    assign s2.wdata   = '0;

    s2_follows_s1: assert property (@(posedge clk) disable iff (!rst_n)
        s1.valid |=> s2.valid);

endmodule

// File: design/lsu_extract.sv
/* stage 3 picks the addressed bytes of a load and extends them to 64 bits
   stores and rejected accesses answer with zero data */
`timescale 1ns/10ps

module lsu_extract
    import mem_cfg_pkg::*, lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    lsu_stage_if.dst        s2,
    output logic            rsp_valid,
    output logic            rsp_err,
    output logic [xlen-1:0] rsp_rdata
);

    logic [xlen-1:0] shifted;
    logic [xlen-1:0] load_value;
    logic            sign;

    always_comb begin
        // addressed byte down to lane 0
        shifted = s2.rdata >> {s2.offset, 3'b000};

        case (s2.width)
            width_byte: begin
                sign       = shifted[7] && !s2.is_unsigned;
                load_value = {{(xlen-8){sign}}, shifted[7:0]};
            end
            width_half: begin
                sign       = shifted[15] && !s2.is_unsigned;
                load_value = {{(xlen-16){sign}}, shifted[15:0]};
            end
            width_word: begin
                sign       = shifted[31] && !s2.is_unsigned;
                load_value = {{(xlen-32){sign}}, shifted[31:0]};
            end
            default: begin
                // full doubleword, nothing to extend
                sign       = 1'b0;
                load_value = shifted;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
        end else begin
            rsp_valid <= s2.valid;
            rsp_err   <= s2.valid && s2.err;
        end
    end

    always_ff @(posedge clk) begin
        if (s2.valid && !s2.we && !s2.err) begin
            rsp_rdata <= load_value;
        end else begin
            rsp_rdata <= '0;
        end
    end

    // a flagged response never carries data
    err_zero_data: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_err |-> rsp_rdata == '0);

endmodule

// File: design/lsu_top.sv
/* three-stage data memory, one access per cycle with no back-pressure
   every request answers exactly three cycles later, in order */
`timescale 1ns/10ps

module lsu_top
    import mem_cfg_pkg::*, lsu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req_valid,
    input  logic            req_we,
    input  logic [xlen-1:0] req_addr,
    input  logic [xlen-1:0] req_wdata,
    input  access_width_t   req_width,
    input  logic            req_unsigned,
    output logic            rsp_valid,
    output logic            rsp_err,
    output logic [xlen-1:0] rsp_rdata
);

    // align to ram
    lsu_stage_if s1 ();
    // ram to extract
    lsu_stage_if s2 ();

    lsu_align i_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_we       (req_we),
        .req_unsigned (req_unsigned),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_width    (req_width),
        .s1           (s1.src)
    );

    lsu_ram i_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .s1    (s1.dst),
        .s2    (s2.src)
    );

    lsu_extract i_extract (
        .clk       (clk),
        .rst_n     (rst_n),
        .s2        (s2.dst),
        .rsp_valid (rsp_valid),
        .rsp_err   (rsp_err),
        .rsp_rdata (rsp_rdata)
    );

endmodule

// File: tb/tb_lsu_top.sv
/* expects one response per request after the three registers of the pipeline
   random traffic stays in a prefilled block, so no load reads unwritten memory */
`timescale 1ns/10ps

module tb_lsu_top
    import mem_cfg_pkg::*, lsu_pkg::*;
();

    localparam int clk_period   = 20;
    localparam int window_bits  = dw_index_bits + dw_offset_bits;
    localparam int window_bytes = int'(ram_bytes);
    localparam int n_directed   = 100;
    localparam int n_fill       = 32;
    localparam int n_random     = 300;
    // a random store may be followed by a load, so count two per step
    localparam int n_tests      = n_directed + n_fill + 2 * n_random;
    localparam int watchdog_cycles = n_tests * 4 + 200;

    localparam logic [xlen-1:0] blk_a     = ram_base + 64'h100;
    localparam logic [xlen-1:0] blk_b     = ram_base + 64'h200;
    localparam logic [xlen-1:0] fill_base = ram_base + 64'h1000;

    logic            clk;
    logic            rst_n;
    logic            req_valid;
    logic            req_we;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] req_wdata;
    access_width_t   req_width;
    logic            req_unsigned;
    logic            rsp_valid;
    logic            rsp_err;
    logic [xlen-1:0] rsp_rdata;

    // byte model of the whole window
    logic [7:0]      ref_mem [window_bytes];

    // expectation of the access being driven now
    logic            exp_in_valid;
    logic            exp_in_err;
    logic [xlen-1:0] exp_in_rdata;

    // expected responses, one slot per pipeline register
    logic            exp_valid [3];
    logic            exp_err   [3];
    logic [xlen-1:0] exp_rdata [3];

    logic [31:0]     rand_state = 32'h7ca5f073;
    int              errors;
    int              n_issued;

    lsu_top i_lsu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_we       (req_we),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_width    (req_width),
        .req_unsigned (req_unsigned),
        .rsp_valid    (rsp_valid),
        .rsp_err      (rsp_err),
        .rsp_rdata    (rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // applies one access to the byte model and works out its response
    task automatic model_access(input logic we, input logic [xlen-1:0] addr,
            input logic [xlen-1:0] wdata, input access_width_t width,
            input logic is_unsigned);
        logic [xlen-1:0] rel;
        logic [xlen-1:0] value;
        logic            bad;
        int              size;
        int              base;
        rel   = addr - ram_base;
        size  = 1 << int'(width);
        bad   = (rel >= ram_bytes) || ((int'(rel[2:0]) % size) != 0);
        base  = int'(rel[window_bits-1:0]);
        value = '0;
        if (!bad && we) begin
            for (int i = 0; i < size; i++) begin
                ref_mem[base + i] = wdata[8*i +: 8];
            end
        end else if (!bad) begin
            for (int i = 0; i < size; i++) begin
                value[8*i +: 8] = ref_mem[base + i];
            end
            if (!is_unsigned && size < 8 && value[8*size-1]) begin
                value = value | ~((64'd1 << (8 * size)) - 64'd1);
            end
        end
        exp_in_err   = bad;
        exp_in_rdata = value;
    endtask

    // drives one request for a single cycle
    task automatic issue(input logic we, input logic [xlen-1:0] addr,
            input logic [xlen-1:0] wdata, input access_width_t width,
            input logic is_unsigned);
        req_valid    = 1'b1;
        req_we       = we;
        req_addr     = addr;
        req_wdata    = wdata;
        req_width    = width;
        req_unsigned = is_unsigned;
        model_access(we, addr, wdata, width, is_unsigned);
        exp_in_valid = 1'b1;
        n_issued++;
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int cycles);
        req_valid    = 1'b0;
        exp_in_valid = 1'b0;
        exp_in_err   = 1'b0;
        exp_in_rdata = '0;
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                exp_valid[i] <= 1'b0;
                exp_err[i]   <= 1'b0;
                exp_rdata[i] <= '0;
            end
        end else begin
            exp_valid[0] <= exp_in_valid;
            exp_err[0]   <= exp_in_err;
            exp_rdata[0] <= exp_in_rdata;
            for (int i = 1; i < 3; i++) begin
                exp_valid[i] <= exp_valid[i-1];
                exp_err[i]   <= exp_err[i-1];
                exp_rdata[i] <= exp_rdata[i-1];
            end
        end
    end

    // also holds rsp_valid low from reset until the first request
    no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> exp_valid[2])
        else begin
            errors++;
            $display("response arrived with no access pending at %0t", $time);
        end

    rsp_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        exp_valid[2] |-> rsp_valid)
        else begin
            errors++;
            $display("an access got no response three cycles after it at %0t", $time);
        end

    rsp_err_match: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && exp_valid[2] |-> rsp_err == exp_err[2])
        else begin
            errors++;
            $display("error rsp_err got %h expected %h",
                     $sampled(rsp_err), $sampled(exp_err[2]));
        end

    rsp_rdata_match: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && exp_valid[2] |-> rsp_rdata == exp_rdata[2])
        else begin
            errors++;
            $display("error rsp_rdata got %h expected %h",
                     $sampled(rsp_rdata), $sampled(exp_rdata[2]));
        end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout, the run did not end within %0d cycles", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]     r;
        logic [2:0]      off;
        logic [xlen-1:0] addr;
        int              size;
        errors       = 0;
        n_issued     = 0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_we       = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_width    = width_byte;
        req_unsigned = 1'b0;
        exp_in_valid = 1'b0;
        exp_in_err   = 1'b0;
        exp_in_rdata = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle(3);

        // every width at every aligned offset, signed and unsigned
        issue(1'b1, blk_a, 64'hf00d_7e57_a5c3_8f19, width_dword, 1'b0);
        for (int wi = 0; wi < 4; wi++) begin
            size = 1 << wi;
            for (int o = 0; o < 8; o += size) begin
                issue(1'b0, blk_a + 64'(o), '0, access_width_t'(wi), 1'b0);
                issue(1'b0, blk_a + 64'(o), '0, access_width_t'(wi), 1'b1);
            end
        end
        idle(2);

        // narrow stores touch only their own lanes
        issue(1'b1, blk_b, 64'h0123_4567_89ab_cdef, width_dword, 1'b0);
        issue(1'b1, blk_b + 64'd1, 64'hffff_ffff_ffff_ff5a, width_byte, 1'b0);
        issue(1'b1, blk_b + 64'd6, 64'h0000_0000_0000_00c3, width_byte, 1'b0);
        issue(1'b1, blk_b + 64'd2, 64'h1111_2222_3333_beef, width_half, 1'b0);
        issue(1'b0, blk_b, '0, width_dword, 1'b0);
        for (int k = 0; k < 16; k++) begin
            r = next_rand();
            if (r[0]) begin
                off = r[3:1];
                issue(1'b1, blk_b + 64'(off), {next_rand(), next_rand()}, width_byte, 1'b0);
            end else begin
                off = {r[3:2], 1'b0};
                issue(1'b1, blk_b + 64'(off), {next_rand(), next_rand()}, width_half, 1'b0);
            end
            issue(1'b0, blk_b, '0, width_dword, 1'b0);
        end
        idle(2);

        // misaligned accesses are rejected and leave memory alone
        issue(1'b1, blk_b + 64'd1, '1, width_half, 1'b0);
        issue(1'b1, blk_b + 64'd2, '1, width_word, 1'b0);
        issue(1'b1, blk_b + 64'd4, '1, width_dword, 1'b0);
        issue(1'b0, blk_b + 64'd3, '0, width_half, 1'b1);
        issue(1'b0, blk_b + 64'd5, '0, width_word, 1'b0);
        issue(1'b0, blk_b, '0, width_dword, 1'b0);
        idle(2);

        // outside the window, including addresses that would alias blk_b
        issue(1'b1, ram_base - 64'd8, '1, width_dword, 1'b0);
        issue(1'b1, ram_base + ram_bytes + 64'h200, '1, width_dword, 1'b0);
        issue(1'b1, 64'h200, '1, width_dword, 1'b0);
        issue(1'b0, ram_base + ram_bytes, '0, width_dword, 1'b0);
        issue(1'b0, ram_base - 64'd1, '0, width_byte, 1'b0);
        issue(1'b0, blk_b, '0, width_dword, 1'b0);
        idle(2);

        for (int i = 0; i < n_fill; i++) begin
            issue(1'b1, fill_base + 64'(8 * i), {next_rand(), next_rand()}, width_dword, 1'b0);
        end

        // mixed back-to-back traffic, a store is often chased by a load
        for (int n = 0; n < n_random; n++) begin
            r    = next_rand();
            size = 1 << int'(r[1:0]);
            off  = r[4:2] & ~3'(size - 1);
            if (r[8:5] == 4'd0 && size > 1) begin
                off = off + 3'd1;
            end
            addr = fill_base + 64'(8 * int'(r[13:9])) + 64'(off);
            issue(r[14], addr, {next_rand(), next_rand()}, access_width_t'(r[1:0]), r[15]);
            if (r[14] && r[16]) begin
                issue(1'b0, fill_base + 64'(8 * int'(r[13:9])), '0, width_dword, 1'b0);
            end
        end

        // drain the three pipeline registers
        idle(4);

        $display("issued %0d accesses, %0d errors", n_issued, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: data_mem.f
design/mem_cfg_pkg.sv
design/lsu_pkg.sv
design/lsu_stage_if.sv
design/lsu_align.sv
design/lsu_ram.sv
design/lsu_extract.sv
design/lsu_top.sv
tb/tb_lsu_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f data_mem.f \
    --top-module tb_lsu_top \
    && ./obj_dir/Vtb_lsu_top | tee /dev/stderr | grep "STATUS: PASS" > /dev/null \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
